//--- list.f
src/switch_pkg.sv
src/port_wr_frontend.sv
src/packet_bank.sv
src/port_queue_set.sv
src/port_rd_engine.sv
src/hydra_switch.sv
sim/tb_hydra_switch.sv

//--- sim/tb_hydra_switch.sv
`timescale 1ns/1ps

module tb_hydra_switch;
    import switch_pkg::*;

    // cycle budget of one test, the watchdog allows this for each test
    localparam int TEST_CYCLES = 20000;
    localparam int N_TESTS     = 6;
    localparam int N_RANDOM    = 80;

    logic                clk;
    logic                rst_n;
    logic [N_PORTS-1:0]  wr_sop;
    logic [N_PORTS-1:0]  wr_eop;
    logic [N_PORTS-1:0]  wr_vld;
    data_t [N_PORTS-1:0] wr_data;
    logic [N_PORTS-1:0]  wr_full;
    logic [N_PORTS-1:0]  ready;
    logic [N_PORTS-1:0]  rd_sop;
    logic [N_PORTS-1:0]  rd_eop;
    logic [N_PORTS-1:0]  rd_vld;
    data_t [N_PORTS-1:0] rd_data;

    // expected packets per output and priority, in join order
    data_t       exp_words [N_PORTS][N_PRIOR][$];
    int          exp_len [N_PORTS][N_PRIOR][$];
    int          arrived_prior [N_PORTS][$];
    int          pending;
    int          sop_seen;
    int          err_cnt;
    logic [31:0] rng;

    hydra_switch #(
        .N_PORTS     (N_PORTS),
        .N_PAGES     (N_PAGES),
        .PAGE_WORDS  (PAGE_WORDS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) hydra_switch_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .wr_full (wr_full),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    initial begin
        repeat (N_TESTS * TEST_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles",
                 N_TESTS * TEST_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string msg);
        err_cnt++;
        $display("Error at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    endtask

    // header word is {spare, prior, dest}, payload words are random
    task automatic make_packet(input int dest, input int prior, input int len,
                               output data_t words[$]);
        logic [31:0] r;
        words.delete();
        r = next_rand();
        words.push_back({r[11:0], prior_t'(prior), port_t'(dest)});
        for (int i = 1; i < len; i++) begin
            r = next_rand();
            words.push_back(r[15:0]);
        end
    endtask

    task automatic expect_packet(input data_t words[$]);
        int dest;
        int prior;
        dest  = words[0][1:0];
        prior = words[0][3:2];
        foreach (words[i]) begin
            exp_words[dest][prior].push_back(words[i]);
        end
        exp_len[dest][prior].push_back(words.size());
        pending++;
    endtask

    task automatic drive_packet(input int port, input data_t words[$], input bit gaps);
        int          i;
        logic [31:0] r;
        @(negedge clk);
        while (wr_full[port]) begin
            @(negedge clk);
        end
        i = 0;
        while (i < words.size()) begin
            @(posedge clk);
            r = next_rand();
            if (gaps && i > 0 && r[0]) begin
                wr_vld[port] <= 1'b0;
                wr_sop[port] <= 1'b0;
                wr_eop[port] <= 1'b0;
            end else begin
                wr_vld[port]  <= 1'b1;
                wr_sop[port]  <= (i == 0);
                wr_eop[port]  <= (i == words.size() - 1);
                wr_data[port] <= words[i];
                i++;
            end
        end
        @(posedge clk);
        wr_vld[port] <= 1'b0;
        wr_sop[port] <= 1'b0;
        wr_eop[port] <= 1'b0;
    endtask

    task automatic send_packet(input int port, input int dest, input int prior,
                               input int len, input bit gaps);
        data_t words[$];
        make_packet(dest, prior, len, words);
        expect_packet(words);
        drive_packet(port, words, gaps);
    endtask

    task automatic wait_room(input int port, input int max_cycles, output bit room);
        room = 1'b0;
        for (int c = 0; c < max_cycles && !room; c++) begin
            @(negedge clk);
            room = !wr_full[port];
        end
    endtask

    task automatic wait_drain();
        while (pending != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_packet(input int o, input data_t pkt[$]);
        int prior;
        int len;
        prior = pkt[0][3:2];
        check_value($sformatf("dest field at output %0d", o), pkt[0][1:0], o);
        if (exp_len[o][prior].size() == 0) begin
            fail_run($sformatf("output %0d delivered a packet that was never sent", o));
        end
        len = exp_len[o][prior].pop_front();
        check_value($sformatf("packet length at output %0d", o), pkt.size(), len);
        foreach (pkt[i]) begin
            check_value($sformatf("output %0d word %0d", o, i), pkt[i],
                        exp_words[o][prior].pop_front());
        end
        arrived_prior[o].push_back(prior);
        pending--;
    endtask

    // framing and content of one output, sampled mid-cycle
    task automatic monitor_port(input int o);
        data_t pkt[$];
        bit    in_pkt;
        in_pkt = 1'b0;
        forever begin
            @(negedge clk);
            if (rd_vld[o]) begin
                if (rd_sop[o]) begin
                    if (in_pkt) begin
                        fail_run($sformatf("output %0d raised rd_sop inside a packet", o));
                    end
                    in_pkt = 1'b1;
                    pkt.delete();
                    sop_seen++;
                end else if (!in_pkt) begin
                    fail_run($sformatf("output %0d sent a word outside a packet", o));
                end
                pkt.push_back(rd_data[o]);
                if (rd_eop[o]) begin
                    in_pkt = 1'b0;
                    compare_packet(o, pkt);
                end
            end else if (rd_sop[o] || rd_eop[o]) begin
                fail_run($sformatf("output %0d raised rd_sop or rd_eop without rd_vld", o));
            end else if (in_pkt) begin
                fail_run($sformatf("output %0d left a gap inside a packet", o));
            end
        end
    endtask

    task automatic test_reset_state();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (wr_full == '1 && cycles < 4 * N_PAGES) begin
            check_value("rd strobes after reset", {rd_sop, rd_eop, rd_vld}, 0);
            cycles++;
            @(negedge clk);
        end
        check_value("cycles of wr_full after reset", cycles, N_PAGES);
        check_value("wr_full once the free list is built", wr_full, 0);
    endtask

    // input in uses priority in, so its packets never share a queue
    task automatic run_singles(input int in);
        int lens[4];
        lens = '{1, PAGE_WORDS, PAGE_WORDS + 1, MAX_PKT_WORDS};
        for (int out = 0; out < N_PORTS; out++) begin
            for (int k = 0; k < 4; k++) begin
                send_packet(in, out, in, lens[k], 1'b0);
            end
        end
    endtask

    task automatic test_single_packets();
        fork
            run_singles(0);
            run_singles(1);
            run_singles(2);
            run_singles(3);
        join
        wait_drain();
    endtask

    task automatic test_priority();
        int sent[6];
        int exp_order[$];
        int sop_before;
        bit room;
        sent = '{1, 3, 0, 2, 3, 1};
        @(posedge clk);
        ready[2] <= 1'b0;
        arrived_prior[2].delete();
        sop_before = sop_seen;
        for (int i = 0; i < 6; i++) begin
            send_packet(1, 2, sent[i], 3 + i, 1'b0);
        end
        wait_room(1, 64, room);
        check_value("input 1 descriptors joined", room, 1);
        check_value("packets started with ready low", sop_seen - sop_before, 0);
        @(posedge clk);
        ready[2] <= 1'b1;
        wait_drain();
        // descending priority, send order inside one level
        for (int p = N_PRIOR - 1; p >= 0; p--) begin
            for (int i = 0; i < 6; i++) begin
                if (sent[i] == p) begin
                    exp_order.push_back(p);
                end
            end
        end
        check_value("packets out at output 2", arrived_prior[2].size(), 6);
        foreach (exp_order[i]) begin
            check_value($sformatf("priority of packet %0d at output 2", i),
                        arrived_prior[2][i], exp_order[i]);
        end
    endtask

    task automatic test_contention();
        data_t pk[N_PORTS][$];
        bit    room;
        // equal lengths end together, ties join lowest bank first
        for (int b = 0; b < N_PORTS; b++) begin
            make_packet(0, 2, 12, pk[b]);
            expect_packet(pk[b]);
        end
        fork
            drive_packet(0, pk[0], 1'b0);
            drive_packet(1, pk[1], 1'b0);
            drive_packet(2, pk[2], 1'b0);
            drive_packet(3, pk[3], 1'b0);
        join
        wait_drain();
        // outputs 1 and 2 both claim bank 3
        @(posedge clk);
        ready[1] <= 1'b0;
        ready[2] <= 1'b0;
        send_packet(3, 1, 0, 20, 1'b0);
        send_packet(3, 2, 0, 20, 1'b0);
        wait_room(3, 64, room);
        check_value("bank 3 descriptors joined", room, 1);
        @(posedge clk);
        ready[1] <= 1'b1;
        ready[2] <= 1'b1;
        wait_drain();
    endtask

    task automatic test_backpressure();
        int expected;
        int n_fill;
        int sop_before;
        bit room;
        // two pages per packet until fewer than MAX_PKT_PAGES stay free
        expected = (N_PAGES - MAX_PKT_PAGES) / (16 / PAGE_WORDS) + 1;
        @(posedge clk);
        ready <= '0;
        sop_before = sop_seen;
        n_fill = 0;
        room = 1'b1;
        while (room && n_fill <= expected) begin
            wait_room(0, 32, room);
            if (room) begin
                send_packet(0, 0, n_fill % N_PRIOR, 16, 1'b0);
                n_fill++;
            end
        end
        check_value("packets stored before wr_full", n_fill, expected);
        check_value("packets started with ready low", sop_seen - sop_before, 0);
        @(posedge clk);
        ready <= '1;
        wait_drain();
        wait_room(0, 64, room);
        check_value("wr_full low after drain", room, 1);
        // more words than one bank holds
        for (int i = 0; i < 10; i++) begin
            send_packet(0, i % N_PORTS, i % N_PRIOR, MAX_PKT_WORDS, 1'b0);
        end
        wait_drain();
    endtask

    task automatic test_random();
        logic [31:0] r;
        int          in;
        int          dest;
        int          prior;
        int          len;
        for (int n = 0; n < N_RANDOM; n++) begin
            r     = next_rand();
            in    = r[1:0];
            dest  = r[3:2];
            prior = r[5:4];
            len   = 1 + (r[15:8] % MAX_PKT_WORDS);
            // keep every priority FIFO within its depth
            while (exp_len[dest][prior].size() >= QUEUE_DEPTH) begin
                @(negedge clk);
            end
            send_packet(in, dest, prior, len, 1'b1);
        end
        wait_drain();
    endtask

    initial begin
        rst_n    = 1'b0;
        wr_sop   = '0;
        wr_eop   = '0;
        wr_vld   = '0;
        wr_data  = '0;
        ready    = '1;
        rng      = 32'h1073_d47b;
        pending  = 0;
        sop_seen = 0;
        err_cnt  = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        fork
            monitor_port(0);
            monitor_port(1);
            monitor_port(2);
            monitor_port(3);
        join_none
        test_reset_state();
        test_single_packets();
        test_priority();
        test_contention();
        test_backpressure();
        test_random();
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- src/hydra_switch.sv
`timescale 1ns/1ps

module hydra_switch #(
    parameter int N_PORTS     = switch_pkg::N_PORTS,
    parameter int N_PAGES     = switch_pkg::N_PAGES,
    parameter int PAGE_WORDS  = switch_pkg::PAGE_WORDS,
    parameter int QUEUE_DEPTH = switch_pkg::QUEUE_DEPTH
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [N_PORTS-1:0]              wr_sop,
    input  logic [N_PORTS-1:0]              wr_eop,
    input  logic [N_PORTS-1:0]              wr_vld,
    input  switch_pkg::data_t [N_PORTS-1:0] wr_data,
    output logic [N_PORTS-1:0]              wr_full,
    input  logic [N_PORTS-1:0]              ready,
    output logic [N_PORTS-1:0]              rd_sop,
    output logic [N_PORTS-1:0]              rd_eop,
    output logic [N_PORTS-1:0]              rd_vld,
    output switch_pkg::data_t [N_PORTS-1:0] rd_data
);
    import switch_pkg::*;

    wr_stream_t  [N_PORTS-1:0] stream;
    pkt_header_t [N_PORTS-1:0] header;
    pkt_desc_t   [N_PORTS-1:0] desc;
    logic        [N_PORTS-1:0] desc_vld;
    logic        [N_PORTS-1:0] desc_ack;
    // join_ack[q][b] is queue set q taking bank b's descriptor
    logic        [N_PORTS-1:0] join_ack [N_PORTS];
    // bank_grant[b][e] seen by the engines as eng_grant[e][b]
    logic        [N_PORTS-1:0] bank_grant [N_PORTS];
    logic        [N_PORTS-1:0] eng_grant [N_PORTS];
    rd_word_t    [N_PORTS-1:0] bank_words;
    logic        [N_PORTS-1:0] claim;
    port_t       [N_PORTS-1:0] claim_bank;
    pkt_desc_t   [N_PORTS-1:0] claim_desc;
    pkt_desc_t   [N_PORTS-1:0] head;
    logic        [N_PORTS-1:0] head_vld;
    logic        [N_PORTS-1:0] pop;

    always_comb begin
        for (int b = 0; b < N_PORTS; b++) begin
            desc_ack[b] = 1'b0;
            for (int p = 0; p < N_PORTS; p++) begin
                desc_ack[b]     = desc_ack[b] | join_ack[p][b];
                eng_grant[p][b] = bank_grant[b][p];
            end
        end
    end

    genvar p;
    generate
        for (p = 0; p < N_PORTS; p++) begin : g_port
            port_wr_frontend frontend_inst (
                .clk     (clk),
                .rst_n   (rst_n),
                .wr_sop  (wr_sop[p]),
                .wr_eop  (wr_eop[p]),
                .wr_vld  (wr_vld[p]),
                .wr_data (wr_data[p]),
                .stream  (stream[p]),
                .header  (header[p])
            );

            // static binding, input p writes only into bank p
            packet_bank #(
                .N_PORTS    (N_PORTS),
                .N_PAGES    (N_PAGES),
                .PAGE_WORDS (PAGE_WORDS)
            ) bank_inst (
                .clk        (clk),
                .rst_n      (rst_n),
                .bank_idx   (port_t'(p)),
                .stream     (stream[p]),
                .header     (header[p]),
                .wr_full    (wr_full[p]),
                .desc       (desc[p]),
                .desc_vld   (desc_vld[p]),
                .desc_ack   (desc_ack[p]),
                .claim      (claim),
                .claim_bank (claim_bank),
                .claim_desc (claim_desc),
                .grant      (bank_grant[p]),
                .rd_word    (bank_words[p])
            );

            port_queue_set #(
                .N_PORTS     (N_PORTS),
                .QUEUE_DEPTH (QUEUE_DEPTH)
            ) queue_inst (
                .clk      (clk),
                .rst_n    (rst_n),
                .port_idx (port_t'(p)),
                .desc     (desc),
                .desc_vld (desc_vld),
                .join_ack (join_ack[p]),
                .pop      (pop[p]),
                .head     (head[p]),
                .head_vld (head_vld[p])
            );

            port_rd_engine #(
                .N_PORTS (N_PORTS)
            ) engine_inst (
                .clk        (clk),
                .rst_n      (rst_n),
                .port_idx   (port_t'(p)),
                .ready      (ready[p]),
                .head       (head[p]),
                .head_vld   (head_vld[p]),
                .pop        (pop[p]),
                .claim      (claim[p]),
                .claim_bank (claim_bank[p]),
                .claim_desc (claim_desc[p]),
                .grant      (eng_grant[p]),
                .bank_words (bank_words),
                .rd_sop     (rd_sop[p]),
                .rd_eop     (rd_eop[p]),
                .rd_vld     (rd_vld[p]),
                .rd_data    (rd_data[p])
            );
        end
    endgenerate

endmodule

//--- src/port_rd_engine.sv
`timescale 1ns/1ps

module port_rd_engine #(
    parameter int N_PORTS = switch_pkg::N_PORTS
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  switch_pkg::port_t                  port_idx,
    input  logic                               ready,
    input  switch_pkg::pkt_desc_t              head,
    input  logic                               head_vld,
    output logic                               pop,
    output logic                               claim,
    output switch_pkg::port_t                  claim_bank,
    output switch_pkg::pkt_desc_t              claim_desc,
    input  logic [N_PORTS-1:0]                 grant,
    input  switch_pkg::rd_word_t [N_PORTS-1:0] bank_words,
    output logic                               rd_sop,
    output logic                               rd_eop,
    output logic                               rd_vld,
    output switch_pkg::data_t                  rd_data
);
    import switch_pkg::*;

    logic     first;
    logic     take;
    rd_word_t in_word;

    // ready is only looked at between packets
    assign pop        = !claim && ready && head_vld && head.dest == port_idx;
    assign claim_bank = claim_desc.bank;
    assign in_word    = bank_words[claim_bank];
    // only words from a bank that granted this engine
    assign take       = claim && grant[claim_bank] && in_word.vld;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            claim <= 1'b0;
            first <= 1'b0;
        end else if (pop) begin
            claim      <= 1'b1;
            first      <= 1'b1;
            claim_desc <= head;
        end else if (take) begin
            first <= 1'b0;
            if (in_word.eop) begin
                claim <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            rd_vld <= take;
            rd_sop <= take && first;
            rd_eop <= take && in_word.eop;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= in_word.data;
    end

endmodule

//--- src/port_queue_set.sv
`timescale 1ns/1ps

module port_queue_set #(
    parameter int N_PORTS     = switch_pkg::N_PORTS,
    parameter int QUEUE_DEPTH = switch_pkg::QUEUE_DEPTH
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  switch_pkg::port_t                   port_idx,
    input  switch_pkg::pkt_desc_t [N_PORTS-1:0] desc,
    input  logic [N_PORTS-1:0]                  desc_vld,
    output logic [N_PORTS-1:0]                  join_ack,
    input  logic                                pop,
    output switch_pkg::pkt_desc_t               head,
    output logic                                head_vld
);
    import switch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    pkt_desc_t          q_mem [N_PRIOR][QUEUE_DEPTH];
    logic [PTR_W-1:0]   q_rd [N_PRIOR];
    logic [PTR_W-1:0]   q_wr [N_PRIOR];
    logic [CNT_W-1:0]   q_cnt [N_PRIOR];
    logic               join_vld;
    port_t              join_bank;
    prior_t             join_prior;
    logic               join_fire;
    prior_t             out_prior;
    logic [N_PRIOR-1:0] push_q;
    logic [N_PRIOR-1:0] pop_q;

    // ties between banks go to the lowest index
    always_comb begin
        join_vld  = 1'b0;
        join_bank = '0;
        for (int b = N_PORTS - 1; b >= 0; b--) begin
            if (desc_vld[b] && desc[b].dest == port_idx) begin
                join_vld  = 1'b1;
                join_bank = port_t'(b);
            end
        end
    end

    assign join_prior = desc[join_bank].prior;
    // a full FIFO holds the ack back, the bank keeps waiting
    assign join_fire  = join_vld && q_cnt[join_prior] != CNT_W'(QUEUE_DEPTH);

    // strict priority, the highest non-empty level wins
    always_comb begin
        head_vld  = 1'b0;
        out_prior = '0;
        for (int p = 0; p < N_PRIOR; p++) begin
            if (q_cnt[p] != '0) begin
                head_vld  = 1'b1;
                out_prior = prior_t'(p);
            end
        end
    end

    assign head = q_mem[out_prior][q_rd[out_prior]];

    always_comb begin
        join_ack            = '0;
        push_q              = '0;
        pop_q               = '0;
        join_ack[join_bank] = join_fire;
        push_q[join_prior]  = join_fire;
        pop_q[out_prior]    = pop && head_vld;
    end

    always_ff @(posedge clk) begin
        if (join_fire) begin
            q_mem[join_prior][q_wr[join_prior]] <= desc[join_bank];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < N_PRIOR; p++) begin
                q_rd[p]  <= '0;
                q_wr[p]  <= '0;
                q_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < N_PRIOR; p++) begin
                if (push_q[p]) begin
                    q_wr[p] <= q_wr[p] + 1'b1;
                end
                if (pop_q[p]) begin
                    q_rd[p] <= q_rd[p] + 1'b1;
                end
                q_cnt[p] <= q_cnt[p] + CNT_W'(push_q[p]) - CNT_W'(pop_q[p]);
            end
        end
    end

endmodule

//--- src/packet_bank.sv
`timescale 1ns/1ps

module packet_bank #(
    parameter int N_PORTS    = switch_pkg::N_PORTS,
    parameter int N_PAGES    = switch_pkg::N_PAGES,
    parameter int PAGE_WORDS = switch_pkg::PAGE_WORDS
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  switch_pkg::port_t                   bank_idx,
    input  switch_pkg::wr_stream_t              stream,
    input  switch_pkg::pkt_header_t             header,
    output logic                                wr_full,
    output switch_pkg::pkt_desc_t               desc,
    output logic                                desc_vld,
    input  logic                                desc_ack,
    input  logic [N_PORTS-1:0]                  claim,
    input  switch_pkg::port_t [N_PORTS-1:0]     claim_bank,
    input  switch_pkg::pkt_desc_t [N_PORTS-1:0] claim_desc,
    output logic [N_PORTS-1:0]                  grant,
    output switch_pkg::rd_word_t                rd_word
);
    import switch_pkg::*;

    localparam int OFF_W  = $clog2(PAGE_WORDS);
    localparam int ADDR_W = $bits(page_t) + OFF_W;
    localparam int CNT_W  = $clog2(N_PAGES + 1);

    data_t            mem [N_PAGES*PAGE_WORDS];
    page_t            next_page [N_PAGES];
    page_t            free_fifo [N_PAGES];
    page_t            fl_rd;
    page_t            fl_wr;
    logic [CNT_W-1:0] free_cnt;
    page_t            init_cnt;
    logic             init_done;
    logic             push;
    page_t            push_page;

    logic              wr_busy;
    page_t             wr_cur;
    page_t             wr_head;
    logic [OFF_W-1:0]  wr_off;
    len_t              wr_len;
    logic              new_page;
    page_t             wr_page;
    logic [OFF_W-1:0]  wr_word_off;
    len_t              wr_len_now;
    logic [ADDR_W-1:0] wr_addr;

    logic              rd_run;
    page_t             rd_page;
    logic [OFF_W-1:0]  rd_off;
    len_t              rd_left;
    logic              rd_page_done;
    logic [ADDR_W-1:0] rd_addr;
    logic              win_vld;
    port_t             win;

    // a fresh page at sop and whenever the previous page filled up
    assign new_page    = stream.vld && (stream.sop || wr_off == '0);
    assign wr_page     = new_page ? free_fifo[fl_rd] : wr_cur;
    assign wr_word_off = stream.sop ? '0 : wr_off;
    assign wr_len_now  = stream.sop ? len_t'(1) : wr_len + len_t'(1);
    assign wr_addr     = {wr_page, wr_word_off};

    always_ff @(posedge clk) begin
        if (stream.vld) begin
            mem[wr_addr] <= stream.word;
        end
        if (new_page && !stream.sop) begin
            next_page[wr_cur] <= wr_page;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_busy  <= 1'b0;
            wr_off   <= '0;
            desc_vld <= 1'b0;
        end else begin
            if (stream.vld) begin
                wr_busy <= !stream.eop;
                wr_off  <= wr_word_off + 1'b1;
                wr_cur  <= wr_page;
                wr_len  <= wr_len_now;
                if (stream.sop) begin
                    wr_head <= wr_page;
                end
            end
            if (stream.vld && stream.eop) begin
                desc_vld   <= 1'b1;
                desc.dest  <= header.dest;
                desc.prior <= header.prior;
                desc.bank  <= bank_idx;
                desc.head  <= stream.sop ? wr_page : wr_head;
                desc.len   <= wr_len_now;
            end else if (desc_ack) begin
                desc_vld <= 1'b0;
            end
        end
    end

    // room for a longest packet, nothing in flight, no descriptor waiting
    assign wr_full = !init_done || free_cnt < CNT_W'(MAX_PKT_PAGES) || desc_vld
                     || wr_busy || stream.vld;

    // free list gets every page after reset and then the pages the reader frees
    assign rd_page_done = rd_run && (rd_off == OFF_W'(PAGE_WORDS - 1) || rd_left == len_t'(1));
    assign push         = !init_done || rd_page_done;
    assign push_page    = init_done ? rd_page : init_cnt;

    always_ff @(posedge clk) begin
        if (push) begin
            free_fifo[fl_wr] <= push_page;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
            fl_rd     <= '0;
            fl_wr     <= '0;
            free_cnt  <= '0;
        end else begin
            if (!init_done) begin
                init_cnt  <= init_cnt + 1'b1;
                init_done <= init_cnt == page_t'(N_PAGES - 1);
            end
            if (push) begin
                fl_wr <= fl_wr + 1'b1;
            end
            if (new_page) begin
                fl_rd <= fl_rd + 1'b1;
            end
            free_cnt <= free_cnt + CNT_W'(push) - CNT_W'(new_page);
        end
    end

    // lowest-index engine claiming this bank
    always_comb begin
        win_vld = 1'b0;
        win     = '0;
        for (int e = N_PORTS - 1; e >= 0; e--) begin
            if (claim[e] && claim_bank[e] == bank_idx) begin
                win_vld = 1'b1;
                win     = port_t'(e);
            end
        end
    end

    assign rd_addr = {rd_page, rd_off};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant       <= '0;
            rd_run      <= 1'b0;
            rd_word.vld <= 1'b0;
            rd_word.eop <= 1'b0;
        end else begin
            rd_word.vld  <= rd_run;
            rd_word.eop  <= rd_run && rd_left == len_t'(1);
            rd_word.data <= mem[rd_addr];
            if (grant == '0 && win_vld) begin
                grant[win] <= 1'b1;
                rd_run     <= 1'b1;
                rd_page    <= claim_desc[win].head;
                rd_off     <= '0;
                rd_left    <= claim_desc[win].len;
            end else begin
                // owner keeps the grant until the eop word is out
                if (rd_word.vld && rd_word.eop) begin
                    grant <= '0;
                end
                if (rd_run) begin
                    rd_left <= rd_left - 1'b1;
                    rd_off  <= rd_off + 1'b1;
                    if (rd_page_done) begin
                        rd_page <= next_page[rd_page];
                        rd_off  <= '0;
                    end
                    if (rd_left == len_t'(1)) begin
                        rd_run <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- src/port_wr_frontend.sv
`timescale 1ns/1ps

module port_wr_frontend (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_sop,
    input  logic                    wr_eop,
    input  logic                    wr_vld,
    input  switch_pkg::data_t       wr_data,
    output switch_pkg::wr_stream_t  stream,
    output switch_pkg::pkt_header_t header
);
    import switch_pkg::*;

    logic      in_pkt;
    logic      accept;
    pkt_word_u word_u;

    // words outside sop..eop are dropped
    assign accept     = wr_vld && (wr_sop || in_pkt);
    assign word_u.raw = wr_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt <= 1'b0;
        end else if (accept) begin
            // a single-word packet opens and closes in the same cycle
            in_pkt <= !wr_eop;
        end
    end

    // one register stage towards the bank
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stream.vld <= 1'b0;
            stream.sop <= 1'b0;
            stream.eop <= 1'b0;
        end else begin
            stream.vld  <= accept;
            stream.sop  <= accept && wr_sop;
            stream.eop  <= accept && wr_eop;
            stream.word <= word_u.raw;
        end
    end

    // header held until the next sop
    always_ff @(posedge clk) begin
        if (accept && wr_sop) begin
            header <= word_u.hdr;
        end
    end

endmodule

//--- src/switch_pkg.sv
package switch_pkg;

    // switch geometry
    localparam int N_PORTS       = 4;
    localparam int N_PRIOR       = 4;
    localparam int PAGE_WORDS    = 8;
    localparam int N_PAGES       = 32;
    localparam int MAX_PKT_WORDS = 64;
    localparam int MAX_PKT_PAGES = MAX_PKT_WORDS / PAGE_WORDS;
    localparam int QUEUE_DEPTH   = 8;

    typedef logic [15:0] data_t;
    typedef logic [4:0]  page_t;
    typedef logic [1:0]  port_t;
    typedef logic [1:0]  prior_t;
    // length in words, 1 to MAX_PKT_WORDS
    typedef logic [6:0]  len_t;

    // first word of a packet, dest in the low bits
    typedef struct packed {
        logic [11:0] spare;
        prior_t      prior;
        port_t       dest;
    } pkt_header_t;

    // the sop word is forwarded as data and also decoded as a header
    typedef union packed {
        data_t       raw;
        pkt_header_t hdr;
    } pkt_word_u;

    typedef struct packed {
        logic  vld;
        logic  sop;
        logic  eop;
        data_t word;
    } wr_stream_t;

    typedef struct packed {
        port_t  dest;
        prior_t prior;
        port_t  bank;
        page_t  head;
        len_t   len;
    } pkt_desc_t;

    typedef struct packed {
        logic  vld;
        logic  eop;
        data_t data;
    } rd_word_t;

endpackage
